// ==== common/exePkg.sv ====
`default_nettype none

package exePkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 4;

    // Top-level instruction class
    typedef enum logic [1:0] {
        CLS_IMM    = 2'b00,
        CLS_REG    = 2'b01,
        CLS_MEM    = 2'b10,
        CLS_BRANCH = 2'b11
    } opClass_t;

    // Second-level decode, bit 3 marks the flag-setting forms
    localparam logic [3:0] FN_ADD  = 4'b0001;
    localparam logic [3:0] FN_SUB  = 4'b0010;
    localparam logic [3:0] FN_AND  = 4'b0011;
    localparam logic [3:0] FN_OR   = 4'b0100;
    localparam logic [3:0] FN_XOR  = 4'b0101;
    localparam logic [3:0] FN_ADDS = 4'b1001;
    localparam logic [3:0] FN_SUBS = 4'b1010;
    localparam logic [3:0] FN_ANDS = 4'b1011;
    localparam logic [3:0] FN_ORS  = 4'b1100;
    localparam logic [3:0] FN_XORS = 4'b1101;

    // Move group
    localparam logic [2:0] MV_MOV  = 3'b000;
    localparam logic [2:0] MV_MOVT = 3'b001;
    localparam logic [2:0] MV_CLR  = 3'b010;
    localparam logic [2:0] MV_SET  = 3'b011;
    localparam logic [2:0] MV_LSL  = 3'b100;
    localparam logic [2:0] MV_LSR  = 3'b101;

    localparam logic [3:0] CC_EQ = 4'b0000;
    localparam logic [3:0] CC_NE = 4'b0001;
    localparam logic [3:0] CC_MI = 4'b0100;

    // Flag write select
    localparam logic [1:0] FW_NONE = 2'b00;
    localparam logic [1:0] FW_NZ   = 2'b01;
    localparam logic [1:0] FW_ALL  = 2'b10;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASSB
    } aluOp_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        opClass_t                opClass;
        logic                    special;
        logic [3:0]              func2;
        logic [2:0]              func3;
        logic [3:0]              cond;
        logic signed [15:0]      imm;
        logic [RegAddrWidth-1:0] rd;
        logic [RegAddrWidth-1:0] rn;
        logic [RegAddrWidth-1:0] rm;
    } exeInstr_t;

    typedef struct packed {
        aluOp_t               op;
        logic [DataWidth-1:0] opA;
        logic [DataWidth-1:0] opB;
        logic                 setNzcv;
        logic                 setNz;
    } aluReq_t;

    typedef struct packed {
        logic [DataWidth-1:0] result;
        flags_t               nzcv;
    } aluRes_t;

    typedef struct packed {
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        logic                 read;
        logic                 write;
    } memReq_t;

    typedef struct packed {
        logic                    en;
        logic [RegAddrWidth-1:0] dest;
        logic [DataWidth-1:0]    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== alu/aluCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCore import exePkg::*; (
    input  aluReq_t req,
    output aluRes_t res
);

    logic [DataWidth:0]   sum;    // One extra bit for carry out
    logic [DataWidth-1:0] result;
    logic                 carry, overflow;
    logic                 signA, signB, signR;

    assign signA = req.opA[DataWidth-1];
    assign signB = req.opB[DataWidth-1];

    always_comb begin
        sum      = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (req.op)
            ALU_ADD: begin
                sum    = {1'b0, req.opA} + {1'b0, req.opB};
                result = sum[DataWidth-1:0];
                carry  = sum[DataWidth];
            end
            ALU_SUB: begin
                sum    = {1'b0, req.opA} - {1'b0, req.opB};
                result = sum[DataWidth-1:0];
                carry  = !sum[DataWidth]; // No borrow
            end
            ALU_AND: result = req.opA & req.opB;
            ALU_OR:  result = req.opA | req.opB;
            ALU_XOR: result = req.opA ^ req.opB;
            ALU_SHL: result = req.opA << req.opB;
            ALU_SHR: result = req.opA >> req.opB;
            default: result = req.opB; // PASSB for the move group
        endcase

        // Signed overflow from operand and result signs
        if (req.op == ALU_ADD) begin
            overflow = !(signA ^ signB) && (signA ^ result[DataWidth-1]);
        end else if (req.op == ALU_SUB) begin
            overflow = (signA ^ signB) && (signA ^ result[DataWidth-1]);
        end
    end

    assign signR = result[DataWidth-1];

    assign res.result = result;
    assign res.nzcv.n = signR;
    assign res.nzcv.z = (result == '0);
    assign res.nzcv.c = carry;    // Zero outside add/sub
    assign res.nzcv.v = overflow;

endmodule

`default_nettype wire

// ==== alu/condUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module condUnit import exePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] flagWrite,
    input  flags_t     newFlags,
    input  logic       branchReq,
    input  logic [3:0] cond,
    output flags_t     flags,
    output logic       branchTaken
);

    logic condMet;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            case (flagWrite)
                FW_ALL: flags <= newFlags;
                FW_NZ: begin
                    flags.n <= newFlags.n; // C and V kept
                    flags.z <= newFlags.z;
                end
                default: ;
            endcase
        end
    end

    // Branch sees flags from before its own cycle
    always_comb begin
        case (cond)
            CC_EQ:   condMet = flags.z;
            CC_NE:   condMet = !flags.z;
            CC_MI:   condMet = flags.n;
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken = branchReq && condMet;

    // Only the two defined write kinds, with clean flag values
    flagWriteLegal: assert property (
        @(posedge clk) disable iff (rst)
        (flagWrite != FW_NONE) |->
            (flagWrite == FW_NZ || flagWrite == FW_ALL) && !$isunknown(newFlags)
    ) else $error("illegal flag write %b with flags %b", flagWrite, newFlags);

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile import exePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  wb_t                     wb,
    input  logic [RegAddrWidth-1:0] rdAddrD,
    input  logic [RegAddrWidth-1:0] rdAddrN,
    input  logic [RegAddrWidth-1:0] rdAddrM,
    output logic [DataWidth-1:0]    rdDataD,
    output logic [DataWidth-1:0]    rdDataN,
    output logic [DataWidth-1:0]    rdDataM
);

    localparam int NumRegs = 1 << RegAddrWidth;

    logic [DataWidth-1:0] regs [NumRegs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // No bypass, a write shows up one cycle later
    assign rdDataD = regs[rdAddrD];
    assign rdDataN = regs[rdAddrN];
    assign rdDataM = regs[rdAddrM];

    // Load data and ALU results must be clean when committed
    wbDataKnown: assert property (
        @(posedge clk) disable iff (rst) wb.en |-> !$isunknown(wb.data)
    ) else $error("regFile write of unknown data to r%0d", wb.dest);

endmodule

`default_nettype wire

// ==== src/exeControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module exeControl import exePkg::*; (
    input  logic                    instrValid,
    input  exeInstr_t               instr,
    input  logic [DataWidth-1:0]    rdDataD,
    input  logic [DataWidth-1:0]    rdDataN,
    input  logic [DataWidth-1:0]    rdDataM,
    input  aluRes_t                 aluRes,
    input  logic [DataWidth-1:0]    memRdata,
    output logic [RegAddrWidth-1:0] rdAddrD,
    output logic [RegAddrWidth-1:0] rdAddrN,
    output logic [RegAddrWidth-1:0] rdAddrM,
    output aluReq_t                 aluReq,
    output wb_t                     wb,
    output memReq_t                 memReq,
    output logic [1:0]              flagWrite,
    output logic                    branchReq,
    output logic [3:0]              cond
);

    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] immZext;
    logic                 writeEn, isLoad, isStore, isBranch;
    logic                 setAll, setNz;

    assign immExt  = {{16{instr.imm[15]}}, instr.imm};
    assign immZext = {16'b0, instr.imm}; // Shift amounts are unsigned

    assign rdAddrD = instr.rd;
    assign rdAddrN = instr.rn;
    assign rdAddrM = instr.rm;

    always_comb begin
        aluReq   = '0;
        aluReq.op = ALU_PASSB;
        writeEn  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        setAll   = 1'b0;
        setNz    = 1'b0;

        case (instr.opClass)
            CLS_REG: begin
                aluReq.opA = rdDataN;
                aluReq.opB = rdDataM;
                writeEn    = 1'b1;
                case (instr.func2)
                    FN_ADD:  aluReq.op = ALU_ADD;
                    FN_SUB:  aluReq.op = ALU_SUB;
                    FN_ADDS: begin
                        aluReq.op = ALU_ADD;
                        setAll    = 1'b1;
                    end
                    FN_SUBS: begin
                        aluReq.op = ALU_SUB;
                        setAll    = 1'b1;
                    end
                    default: writeEn = 1'b0;
                endcase
            end
            CLS_IMM: begin
                writeEn = 1'b1;
                if (instr.special) begin
                    aluReq.opA = rdDataN;
                    aluReq.opB = immExt;
                    setNz      = instr.func2[3]; // S forms have bit 3 set
                    case (instr.func2)
                        FN_ADD, FN_ADDS: aluReq.op = ALU_ADD;
                        FN_SUB, FN_SUBS: aluReq.op = ALU_SUB;
                        FN_AND, FN_ANDS: aluReq.op = ALU_AND;
                        FN_OR,  FN_ORS:  aluReq.op = ALU_OR;
                        FN_XOR, FN_XORS: aluReq.op = ALU_XOR;
                        default: begin
                            writeEn = 1'b0;
                            setNz   = 1'b0;
                        end
                    endcase
                    // Arithmetic S forms update C and V too
                    if (setNz && (aluReq.op == ALU_ADD || aluReq.op == ALU_SUB)) begin
                        setAll = 1'b1;
                        setNz  = 1'b0;
                    end
                end else begin
                    aluReq.opA = rdDataN;
                    case (instr.func3)
                        MV_MOV:  aluReq.opB = immExt;
                        MV_MOVT: aluReq.opB = {instr.imm, rdDataD[15:0]};
                        MV_CLR:  aluReq.opB = '0;
                        MV_SET:  aluReq.opB = '1;
                        MV_LSL: begin
                            aluReq.op  = ALU_SHL;
                            aluReq.opB = immZext;
                        end
                        MV_LSR: begin
                            aluReq.op  = ALU_SHR;
                            aluReq.opB = immZext;
                        end
                        default: writeEn = 1'b0;
                    endcase
                end
            end
            CLS_MEM: begin
                aluReq.op  = ALU_ADD; // Base plus offset
                aluReq.opA = rdDataN;
                aluReq.opB = immExt;
                isStore    = instr.func3[0];
                isLoad     = !instr.func3[0];
                writeEn    = isLoad;
            end
            CLS_BRANCH: isBranch = 1'b1;
            default: ;
        endcase

        aluReq.setNzcv = instrValid && setAll;
        aluReq.setNz   = instrValid && setNz;
    end

    assign wb.en   = instrValid && writeEn;
    assign wb.dest = instr.rd;
    assign wb.data = isLoad ? memRdata : aluRes.result;

    assign memReq.addr  = aluRes.result;
    assign memReq.wdata = rdDataD;
    assign memReq.read  = instrValid && isLoad;
    assign memReq.write = instrValid && isStore;

    assign flagWrite = aluReq.setNzcv ? FW_ALL : (aluReq.setNz ? FW_NZ : FW_NONE);
    assign branchReq = instrValid && isBranch;
    assign cond      = instr.cond;

    // Address comes back from the ALU as base plus offset
    memAddrSum: assert final (
        !(memReq.read || memReq.write) || memReq.addr == rdDataN + immExt
    ) else $error("memory address %h is not base plus offset", memReq.addr);

endmodule

`default_nettype wire

// ==== src/exeCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module exeCore import exePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  exeInstr_t            instr,
    input  logic [DataWidth-1:0] memRdata,
    output memReq_t              memReq,
    output wb_t                  wb,
    output logic                 branchTaken
);

    logic [RegAddrWidth-1:0] rdAddrD, rdAddrN, rdAddrM;
    logic [DataWidth-1:0]    rdDataD, rdDataN, rdDataM;
    aluReq_t                 aluReq;
    aluRes_t                 aluRes;
    logic [1:0]              flagWrite;
    logic                    branchReq;
    logic [3:0]              cond;

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rdAddrD (rdAddrD),
        .rdAddrN (rdAddrN),
        .rdAddrM (rdAddrM),
        .rdDataD (rdDataD),
        .rdDataN (rdDataN),
        .rdDataM (rdDataM)
    );

    exeControl i_control (
        .instrValid (instrValid),
        .instr      (instr),
        .rdDataD    (rdDataD),
        .rdDataN    (rdDataN),
        .rdDataM    (rdDataM),
        .aluRes     (aluRes),
        .memRdata   (memRdata),
        .rdAddrD    (rdAddrD),
        .rdAddrN    (rdAddrN),
        .rdAddrM    (rdAddrM),
        .aluReq     (aluReq),
        .wb         (wb),
        .memReq     (memReq),
        .flagWrite  (flagWrite),
        .branchReq  (branchReq),
        .cond       (cond)
    );

    aluCore i_alu (
        .req (aluReq),
        .res (aluRes)
    );

    // Flag value only feeds the branch decision for now
    condUnit i_cond (
        .clk         (clk),
        .rst         (rst),
        .flagWrite   (flagWrite),
        .newFlags    (aluRes.nzcv),
        .branchReq   (branchReq),
        .cond        (cond),
        .flags       (),
        .branchTaken (branchTaken)
    );

endmodule

`default_nettype wire

// ==== test/tbTasks.svh ====
task automatic reportMismatch(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
endtask

// Packs the instruction fields
function automatic exeInstr_t encode(input opClass_t cls, input logic special,
        input logic [3:0] func2, input logic [2:0] func3, input logic [3:0] cond,
        input logic [15:0] imm, input logic [3:0] rd, input logic [3:0] rn,
        input logic [3:0] rm);
    exeInstr_t ins;
    ins.opClass = cls;
    ins.special = special;
    ins.func2   = func2;
    ins.func3   = func3;
    ins.cond    = cond;
    ins.imm     = imm;
    ins.rd      = rd;
    ins.rn      = rn;
    ins.rm      = rm;
    return ins;
endfunction

// Drives one instruction, checks the same-cycle response, then updates the model
task automatic issue(input exeInstr_t ins, input logic valid);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] immS;
    logic [31:0] expData;
    logic [31:0] expAddr;
    logic        expEn;
    logic        expRead;
    logic        expWrite;
    logic        expTaken;
    logic [1:0]  flagSel;  // 0 none, 1 N and Z, 2 all four
    flags_t      fl;
    a        = refRegs[ins.rn];
    b        = refRegs[ins.rm];
    d        = refRegs[ins.rd];
    immS     = 32'($signed(ins.imm));
    expData  = '0;
    expAddr  = '0;
    expEn    = 1'b0;
    expRead  = 1'b0;
    expWrite = 1'b0;
    expTaken = 1'b0;
    flagSel  = 2'd0;
    fl       = '0;
    case (ins.opClass)
        CLS_REG: begin
            if (ins.func2 inside {FN_ADD, FN_SUB, FN_ADDS, FN_SUBS}) begin
                {fl, expData} = addSubRef(a, b, ins.func2 inside {FN_SUB, FN_SUBS});
                expEn = 1'b1;
                if (ins.func2[3]) flagSel = 2'd2;
            end
        end
        CLS_IMM: begin
            expEn = 1'b1;
            if (ins.special) begin
                case (ins.func2)
                    FN_ADD, FN_ADDS: {fl, expData} = addSubRef(a, immS, 1'b0);
                    FN_SUB, FN_SUBS: {fl, expData} = addSubRef(a, immS, 1'b1);
                    FN_AND, FN_ANDS: expData = a & immS;
                    FN_OR, FN_ORS:   expData = a | immS;
                    FN_XOR, FN_XORS: expData = a ^ immS;
                    default:         expEn = 1'b0;
                endcase
                if (ins.func2 inside {FN_ADDS, FN_SUBS}) flagSel = 2'd2;
                if (ins.func2 inside {FN_ANDS, FN_ORS, FN_XORS}) begin
                    fl.n    = expData[31];
                    fl.z    = (expData == 32'd0);
                    flagSel = 2'd1;
                end
            end else begin
                case (ins.func3)
                    MV_MOV:  expData = immS;
                    MV_MOVT: expData = {ins.imm, d[15:0]}; // Low half of Rd kept
                    MV_CLR:  expData = 32'h0000_0000;
                    MV_SET:  expData = 32'hFFFF_FFFF;
                    MV_LSL:  expData = a << $unsigned(ins.imm);
                    MV_LSR:  expData = a >> $unsigned(ins.imm);
                    default: expEn = 1'b0;
                endcase
            end
        end
        CLS_MEM: begin
            expAddr = a + immS;
            if (ins.func3[0]) begin
                expWrite = 1'b1;
            end else begin
                expRead = 1'b1;
                expEn   = 1'b1;
                expData = refMem[expAddr[7:2]];
            end
        end
        default: begin
            case (ins.cond)
                CC_EQ:   expTaken = refFlags.z;
                CC_NE:   expTaken = !refFlags.z;
                CC_MI:   expTaken = refFlags.n;
                default: expTaken = 1'b0;
            endcase
        end
    endcase
    if (!valid) begin
        expEn    = 1'b0;
        expRead  = 1'b0;
        expWrite = 1'b0;
        expTaken = 1'b0;
        flagSel  = 2'd0;
    end

    @(posedge clk);
    #1;
    instrValid = valid;
    instr      = ins;
    issued++;
    #2; // Sample 1 ns before the commit edge
    seenData  = wb.data;
    seenTaken = branchTaken;
    if (wb.en !== expEn) reportMismatch("wb.en", wb.en, expEn);
    if (expEn && wb.dest !== ins.rd) reportMismatch("wb.dest", wb.dest, ins.rd);
    if (expEn && wb.data !== expData) reportMismatch("wb.data", wb.data, expData);
    if (memReq.read !== expRead) reportMismatch("memReq.read", memReq.read, expRead);
    if (memReq.write !== expWrite) reportMismatch("memReq.write", memReq.write, expWrite);
    if ((expRead || expWrite) && memReq.addr !== expAddr) begin
        reportMismatch("memReq.addr", memReq.addr, expAddr);
    end
    if (expWrite && memReq.wdata !== d) reportMismatch("memReq.wdata", memReq.wdata, d);
    if (branchTaken !== expTaken) reportMismatch("branchTaken", branchTaken, expTaken);

    if (expEn) refRegs[ins.rd] = expData;
    if (expWrite) refMem[expAddr[7:2]] = d;
    if (flagSel == 2'd2) begin
        refFlags = fl;
    end else if (flagSel == 2'd1) begin
        refFlags.n = fl.n;
        refFlags.z = fl.z;
    end
endtask

task automatic runReg(input logic [3:0] func2, input logic [3:0] rd, rn, rm);
    issue(encode(CLS_REG, 1'b0, func2, 3'd0, 4'd0, 16'd0, rd, rn, rm), 1'b1);
endtask

task automatic runImm(input logic [3:0] func2, input logic [3:0] rd, rn,
                      input logic [15:0] imm);
    issue(encode(CLS_IMM, 1'b1, func2, 3'd0, 4'd0, imm, rd, rn, 4'd0), 1'b1);
endtask

task automatic runMove(input logic [2:0] func3, input logic [3:0] rd, rn,
                       input logic [15:0] imm);
    issue(encode(CLS_IMM, 1'b0, 4'd0, func3, 4'd0, imm, rd, rn, 4'd0), 1'b1);
endtask

task automatic runMem(input logic store, input logic [3:0] rd, rn, input logic [15:0] imm);
    issue(encode(CLS_MEM, 1'b0, 4'd0, {2'b00, store}, 4'd0, imm, rd, rn, 4'd0), 1'b1);
endtask

task automatic runBranch(input logic [3:0] cond);
    issue(encode(CLS_BRANCH, 1'b0, 4'd0, 3'd0, cond, 16'd0, 4'd0, 4'd0, 4'd0), 1'b1);
endtask

task automatic branchesAll();
    runBranch(CC_EQ);
    runBranch(CC_NE);
    runBranch(CC_MI);
endtask

// MOV for the low half, then MOVT for the upper half
task automatic loadReg(input logic [3:0] rd, input logic [31:0] value);
    runMove(MV_MOV, rd, 4'd0, value[15:0]);
    runMove(MV_MOVT, rd, 4'd0, value[31:16]);
endtask

task automatic testStrobeReset();
    runBranch(CC_NE); // Z clear after reset
    if (seenTaken !== 1'b1) reportMismatch("BNE after reset", seenTaken, 1'b1);
    loadReg(4'd1, 32'h0000_1234);
    // Masked instructions of every class
    issue(encode(CLS_IMM, 1'b0, 4'd0, MV_SET, 4'd0, 16'd0, 4'd1, 4'd0, 4'd0), 1'b0);
    issue(encode(CLS_REG, 1'b0, FN_SUBS, 3'd0, 4'd0, 16'd0, 4'd2, 4'd1, 4'd1), 1'b0);
    issue(encode(CLS_MEM, 1'b0, 4'd0, 3'd1, 4'd0, 16'h0020, 4'd1, 4'd0, 4'd0), 1'b0);
    issue(encode(CLS_MEM, 1'b0, 4'd0, 3'd0, 4'd0, 16'h0020, 4'd3, 4'd0, 4'd0), 1'b0);
    issue(encode(CLS_BRANCH, 1'b0, 4'd0, 3'd0, CC_NE, 16'd0, 4'd0, 4'd0, 4'd0), 1'b0);
    runBranch(CC_NE);
    if (seenTaken !== 1'b1) reportMismatch("BNE after masked SUBS", seenTaken, 1'b1);
    runReg(FN_ADD, 4'd2, 4'd1, 4'd0);
    if (seenData !== 32'h0000_1234) reportMismatch("r1 after masked SET", seenData, 32'h1234);
    runMem(1'b0, 4'd3, 4'd0, 16'h0020);
    if (seenData !== fillWord(8)) reportMismatch("word after masked store", seenData,
                                                 fillWord(8));
endtask

task automatic testMoves();
    runMove(MV_MOV, 4'd1, 4'd0, 16'h8001);
    if (seenData !== 32'hFFFF_8001) reportMismatch("MOV sign extension", seenData,
                                                   32'hFFFF_8001);
    runMove(MV_MOVT, 4'd1, 4'd0, 16'h1234);
    if (seenData !== 32'h1234_8001) reportMismatch("MOVT", seenData, 32'h1234_8001);
    runMove(MV_MOV, 4'd3, 4'd0, 16'h7FFF);
    runMove(MV_SET, 4'd2, 4'd0, 16'd0);
    if (seenData !== 32'hFFFF_FFFF) reportMismatch("SET", seenData, 32'hFFFF_FFFF);
    runMove(MV_CLR, 4'd2, 4'd0, 16'd0);
    if (seenData !== 32'h0000_0000) reportMismatch("CLR", seenData, 32'h0);
endtask

task automatic testRegArith();
    logic [31:0] x;
    logic [31:0] y;
    for (int k = 0; k < 8; k++) begin
        x = $urandom;
        y = $urandom;
        if (k == 1) begin
            x = 32'h7FFF_FFFF; // Signed overflow on add
            y = 32'h0000_0001;
        end
        loadReg(4'd4, x);
        loadReg(4'd5, y);
        runReg(FN_ADD, 4'd6, 4'd4, 4'd5);
        runReg(FN_SUB, 4'd7, 4'd4, 4'd5);
        runReg(FN_ADDS, 4'd8, 4'd4, 4'd5);
        branchesAll();
        runReg(FN_SUBS, 4'd9, 4'd4, 4'd5);
        branchesAll();
    end
    loadReg(4'd5, x);
    runReg(FN_SUBS, 4'd9, 4'd4, 4'd5);
    runBranch(CC_EQ);
    if (seenTaken !== 1'b1) reportMismatch("BEQ after SUBS of equal values", seenTaken, 1'b1);
endtask

task automatic testImmArith();
    logic [31:0] x;
    logic [15:0] imm;
    for (int k = 0; k < 4; k++) begin
        x   = $urandom;
        imm = 16'h8000 | 16'($urandom); // Negative offset
        loadReg(4'd4, x);
        runImm(FN_ADD, 4'd6, 4'd4, imm);
        runImm(FN_SUB, 4'd6, 4'd4, imm);
        runImm(FN_AND, 4'd6, 4'd4, imm);
        runImm(FN_OR, 4'd6, 4'd4, imm);
        runImm(FN_XOR, 4'd6, 4'd4, imm);
        runImm(FN_ORS, 4'd7, 4'd4, imm);
        branchesAll();
        runImm(FN_XORS, 4'd7, 4'd4, imm);
        branchesAll();
    end
    // Carry out of ADDS, then an ANDS that only touches N and Z
    loadReg(4'd4, 32'hFFFF_FFFF);
    runImm(FN_ADDS, 4'd6, 4'd4, 16'h0001);
    runBranch(CC_EQ);
    if (seenTaken !== 1'b1) reportMismatch("BEQ after ADDS to zero", seenTaken, 1'b1);
    runImm(FN_ANDS, 4'd7, 4'd4, 16'h8000);
    runBranch(CC_MI);
    if (seenTaken !== 1'b1) reportMismatch("BMI after ANDS", seenTaken, 1'b1);
    runBranch(CC_EQ);
    if (seenTaken !== 1'b0) reportMismatch("BEQ after ANDS", seenTaken, 1'b0);
    runImm(FN_SUBS, 4'd8, 4'd4, 16'hFFFF);
    runBranch(CC_EQ);
endtask

task automatic testShifts();
    int amt;
    loadReg(4'd4, $urandom);
    runMove(MV_LSL, 4'd6, 4'd4, 16'd0);
    runMove(MV_LSR, 4'd7, 4'd4, 16'd31);
    for (int k = 0; k < 6; k++) begin
        amt = $urandom_range(31, 0);
        runMove(MV_LSL, 4'd6, 4'd4, 16'(amt));
        runMove(MV_LSR, 4'd7, 4'd4, 16'(amt));
    end
endtask

task automatic testMemory();
    logic [31:0] val0;
    logic [31:0] val1;
    val0 = $urandom;
    val1 = $urandom;
    loadReg(4'd4, 32'h0000_0040);
    loadReg(4'd10, 32'h0000_0080);
    loadReg(4'd5, val0);
    loadReg(4'd11, val1);
    runMem(1'b1, 4'd5, 4'd4, 16'h0010);   // 0x50
    runMem(1'b1, 4'd11, 4'd10, 16'hFFF8); // 0x78
    runMem(1'b0, 4'd6, 4'd4, 16'h0010);
    if (seenData !== val0) reportMismatch("load after store at 0x50", seenData, val0);
    runMem(1'b0, 4'd7, 4'd10, 16'hFFF8);
    if (seenData !== val1) reportMismatch("load after store at 0x78", seenData, val1);
    runMem(1'b0, 4'd8, 4'd4, 16'hFFC4);   // 0x04, never written
    if (seenData !== fillWord(1)) reportMismatch("load at 0x04", seenData, fillWord(1));
endtask

// ==== test/tbExeCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbExeCore import exePkg::*; ();

    localparam int ClkPeriod    = 4;
    localparam int ResetCycles  = 2;
    localparam int MaxInstr     = 300; // Upper bound over all directed tests
    localparam int MarginCycles = 50;

    logic                 clk;
    logic                 rst;
    logic                 instrValid;
    exeInstr_t            instr;
    logic [DataWidth-1:0] memRdata;
    memReq_t              memReq;
    wb_t                  wb;
    logic                 branchTaken;

    logic [DataWidth-1:0] mem [64];     // Memory model seen by the DUT
    logic [DataWidth-1:0] refMem [64];  // Expected memory contents
    logic [DataWidth-1:0] refRegs [16];
    flags_t               refFlags;
    logic [DataWidth-1:0] seenData;     // Last sampled wb.data
    logic                 seenTaken;
    int                   errors;
    int                   issued;

    exeCore i_dut (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .memRdata    (memRdata),
        .memReq      (memReq),
        .wb          (wb),
        .branchTaken (branchTaken)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Combinational read, write on the clock edge
    assign memRdata = memReq.read ? mem[memReq.addr[7:2]] : '0;

    always @(posedge clk) begin
        if (memReq.write) begin
            mem[memReq.addr[7:2]] <= memReq.wdata;
        end
    end

    // Initial word built from its full byte address
    function automatic logic [31:0] fillWord(input int idx);
        logic [15:0] byteAddr;
        byteAddr = 16'(idx * 4);
        return {~byteAddr, byteAddr};
    endfunction

    // Add or subtract with NZCV, C on subtract means no borrow
    function automatic logic [35:0] addSubRef(input logic [31:0] x, input logic [31:0] y,
                                              input logic isSub);
        logic [32:0] wide;
        logic [31:0] r;
        logic        c;
        logic        v;
        if (isSub) begin
            r = x - y;
            c = (x >= y);
            v = (x[31] != y[31]) && (r[31] != x[31]);
        end else begin
            wide = {1'b0, x} + {1'b0, y};
            r    = wide[31:0];
            c    = wide[32];
            v    = (x[31] == y[31]) && (r[31] != x[31]);
        end
        return {r[31], r == 32'd0, c, v, r};
    endfunction

    `include "tbTasks.svh"

    // Watchdog
    initial begin
        #((MaxInstr + ResetCycles + MarginCycles) * ClkPeriod);
        $display("Timeout: the tests did not finish within the time for %0d instructions",
                 MaxInstr);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h7819_7b3f));
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        errors     = 0;
        issued     = 0;
        refFlags   = '0;
        seenData   = '0;
        seenTaken  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 16; i++) begin
            refRegs[i] = '0;
        end

        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        testStrobeReset();
        testMoves();
        testRegArith();
        testImmArith();
        testShifts();
        testMemory();

        @(posedge clk);
        #1;
        instrValid = 1'b0;
        $display("Errors: %0d over %0d issued instructions", errors, issued);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
common/exePkg.sv
alu/aluCore.sv
alu/condUnit.sv
src/regFile.sv
src/exeControl.sv
src/exeCore.sv
test/tbExeCore.sv

// ==== Bender.yml ====
package:
  name: exe_core

sources:
  - common/exePkg.sv
  - alu/aluCore.sv
  - alu/condUnit.sv
  - src/regFile.sv
  - src/exeControl.sv
  - src/exeCore.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbExeCore.sv
